//--- design/bp_macros.svh
`ifndef BP_MACROS_SVH
`define BP_MACROS_SVH

// cache geometry
`define LINE_BYTES 64      // bytes per line
`define SLOTS 4            // max instructions per bundle
`define L0_SETS 8          // direct mapped, one line per set

// return stack
`define RAS_DEPTH 8

// gshare sizing
`define GHR_BITS 4         // global history length
`define PHT_PC_BITS 4      // pc bits 5..2 in the index

// fetch side flow control
`define FETCH_CREDITS 4    // bundles fetch can buffer

`define RESET_PC 64'h0

`endif

//--- design/bp_pkg.sv
`default_nettype none

`include "bp_macros.svh"

package bp_pkg;

  typedef logic [63:0] pc_t;    // instruction address
  typedef logic [31:0] instr_t;
  typedef logic [511:0] line_t; // byte i at bits 8i+7..8i
  typedef logic [1:0] slot_t;   // slot index in a bundle
  typedef logic [2:0] slot_cnt_t; // 1..4 slots
  typedef logic [1:0] ctr_t;    // saturating 2 bit counter

  typedef logic [`GHR_BITS-1:0] ghr_t;
  // history on top, pc bits below
  typedef logic [`GHR_BITS+`PHT_PC_BITS-1:0] pht_idx_t;

  typedef logic [2:0] ras_ptr_t;

  // control instruction found in a bundle
  typedef enum logic [2:0] {
    BR_NONE,
    BR_B,
    BR_BL,
    BR_RET,
    BR_COND
  } br_kind_t;

  typedef enum logic {
    ST_LOOKUP,   // probe l0 every cycle
    ST_WAIT_L1   // one line outstanding at l1i
  } bp_state_t;

endpackage

`default_nettype wire

//--- design/ret_addr_stack.sv
`timescale 1ns/100ps
`default_nettype none

`include "bp_macros.svh"

module ret_addr_stack import bp_pkg::*; (
  input  wire logic clk_in,
  input  wire logic rst_N_in,
  input  wire logic push,
  input  wire logic pop,
  input  wire pc_t  push_pc,
  output pc_t       top_pc
);

  pc_t      stack_mem [`RAS_DEPTH]; // circular, oldest entry gets overwritten
  ras_ptr_t tos;                    // points at the current top

  assign top_pc = stack_mem[tos];

  // pointer only, wraps naturally at depth 8
  always_ff @(posedge clk_in) begin
    if (rst_N_in) begin
      tos <= '0;
    end else if (push && !pop) begin
      tos <= tos + ras_ptr_t'(1);
    end else if (pop && !push) begin
      tos <= tos - ras_ptr_t'(1); // underflow just wraps
    end
  end

  always_ff @(posedge clk_in) begin
    if (push && pop) begin
      stack_mem[tos] <= push_pc;  // replace top in place
    end else if (push) begin
      stack_mem[tos + ras_ptr_t'(1)] <= push_pc;
    end
  end

endmodule

`default_nettype wire

//--- design/l0_icache.sv
`timescale 1ns/100ps
`default_nettype none

`include "bp_macros.svh"

module l0_icache import bp_pkg::*; (
  input  wire logic  clk_in,
  input  wire logic  rst_N_in,
  input  wire pc_t   lookup_pc,
  output logic       hit,
  output line_t      line,
  input  wire logic  fill,
  input  wire pc_t   fill_pc,
  input  wire line_t fill_line
);

  localparam int OFF_BITS = $clog2(`LINE_BYTES);    // 6
  localparam int IDX_BITS = $clog2(`L0_SETS);       // 3
  localparam int TAG_BITS = 64 - OFF_BITS - IDX_BITS;

  logic [TAG_BITS-1:0] tag_mem  [`L0_SETS];
  line_t               data_mem [`L0_SETS];
  logic [`L0_SETS-1:0] valid;

  logic [IDX_BITS-1:0] lk_idx;
  logic [IDX_BITS-1:0] fl_idx;

  assign lk_idx = lookup_pc[OFF_BITS +: IDX_BITS]; // pc[8:6]
  assign fl_idx = fill_pc[OFF_BITS +: IDX_BITS];

  // combinational probe
  assign hit  = valid[lk_idx] && (tag_mem[lk_idx] == lookup_pc[63 -: TAG_BITS]);
  assign line = data_mem[lk_idx];

  always_ff @(posedge clk_in) begin
    if (rst_N_in) begin
      valid <= '0;
    end else if (fill) begin
      valid[fl_idx] <= 1'b1;
    end
  end

  // tag and data written together on fill
  always_ff @(posedge clk_in) begin
    if (fill) begin
      tag_mem[fl_idx]  <= fill_pc[63 -: TAG_BITS];
      data_mem[fl_idx] <= fill_line;
    end
  end

endmodule

`default_nettype wire

//--- design/gshare_pht.sv
`timescale 1ns/100ps
`default_nettype none

`include "bp_macros.svh"

module gshare_pht import bp_pkg::*; (
  input  wire logic clk_in,
  input  wire logic rst_N_in,
  input  wire logic resolve,
  input  wire logic taken,
  input  wire pc_t  resolve_pc,
  input  wire pc_t  lookup_pc,
  output logic      predict_taken,
  output ghr_t      history
);

  localparam int PHT_SIZE = 1 << $bits(pht_idx_t); // 256 counters

  ctr_t     pht [PHT_SIZE];
  ghr_t     ghr;
  pht_idx_t rd_idx;
  pht_idx_t wr_idx;
  ctr_t     wr_ctr;

  // history above pc[5:2]
  assign rd_idx = {ghr, lookup_pc[2 +: `PHT_PC_BITS]};
  assign wr_idx = {ghr, resolve_pc[2 +: `PHT_PC_BITS]};
  assign wr_ctr = pht[wr_idx];

  assign predict_taken = pht[rd_idx][1]; // weakly taken or above
  assign history       = ghr;

  always_ff @(posedge clk_in) begin
    if (rst_N_in) begin
      ghr <= '0;
      pht <= '{default: '0};
    end else if (resolve) begin
      if (taken && wr_ctr != 2'd3) begin
        pht[wr_idx] <= wr_ctr + ctr_t'(1);
      end else if (!taken && wr_ctr != 2'd0) begin
        pht[wr_idx] <= wr_ctr - ctr_t'(1);
      end
      // newest outcome lands in bit 0
      ghr <= {ghr[`GHR_BITS-2:0], taken};
    end
  end

endmodule

`default_nettype wire

//--- design/predecode.sv
`timescale 1ns/100ps
`default_nettype none

`include "bp_macros.svh"

module predecode import bp_pkg::*; (
  input  wire pc_t   pc,
  input  wire line_t line,
  input  wire pc_t   ras_top,
  input  wire logic  cond_taken,
  output pc_t        cond_pc,
  output slot_cnt_t  slot_count,
  output logic       br_valid,
  output logic       br_taken,
  output br_kind_t   br_kind,
  output slot_t      br_slot,
  output pc_t        br_target,
  output pc_t        next_pc,
  output logic       ras_push,
  output logic       ras_pop,
  output pc_t        ras_push_pc
);

  localparam int OFF_BITS  = $clog2(`LINE_BYTES);
  localparam int LEFT_BITS = OFF_BITS + 1; // holds 4..64

  instr_t              slot_instr [`SLOTS];
  br_kind_t            slot_kind  [`SLOTS];
  logic [LEFT_BITS-1:0] bytes_left;
  slot_cnt_t           avail;     // slots before line end
  logic                found;     // control instr in the bundle
  slot_t               ctl_slot;
  br_kind_t            ctl_kind;
  instr_t              ctl_instr;
  pc_t                 slot_pc;   // pc of the control slot
  pc_t                 b_target;
  pc_t                 c_target;
  pc_t                 seq_pc;

  function automatic br_kind_t classify(input instr_t ins);
    br_kind_t k;
    k = BR_NONE;
    if (ins[31:21] == 11'b11010110010) begin
      k = BR_RET;
    end else if (ins[31:26] == 6'b000101) begin
      k = BR_B;
    end else if (ins[31:26] == 6'b100101) begin
      k = BR_BL;
    end else if (ins[31:24] == 8'b01010100) begin
      k = BR_COND;
    end
    return k;
  endfunction

  assign bytes_left = LEFT_BITS'(`LINE_BYTES) - {1'b0, pc[OFF_BITS-1:0]};
  assign avail = (bytes_left >= LEFT_BITS'(4 * `SLOTS)) ? slot_cnt_t'(`SLOTS)
                                                        : slot_cnt_t'(bytes_left >> 2);

  // little endian words straight out of the line
  for (genvar i = 0; i < `SLOTS; i++) begin : g_slot
    logic [OFF_BITS-1:0] off;
    assign off           = pc[OFF_BITS-1:0] + OFF_BITS'(4 * i); // wraps past end, masked by avail
    assign slot_instr[i] = line[{off, 3'b000} +: 32];
    assign slot_kind[i]  = classify(slot_instr[i]);
  end

  // first control instruction ends the bundle
  always_comb begin
    found    = 1'b0;
    ctl_slot = '0;
    ctl_kind = BR_NONE;
    for (int i = 0; i < `SLOTS; i++) begin
      if (!found && slot_cnt_t'(i) < avail && slot_kind[i] != BR_NONE) begin
        found    = 1'b1;
        ctl_slot = slot_t'(i);
        ctl_kind = slot_kind[i];
      end
    end
  end

  assign ctl_instr = slot_instr[ctl_slot];
  assign slot_pc   = pc + {60'b0, ctl_slot, 2'b00};
  assign cond_pc   = slot_pc;   // pht probe for a b.cond here

  // imm26 and imm19, scaled by 4
  assign b_target = slot_pc + {{36{ctl_instr[25]}}, ctl_instr[25:0], 2'b00};
  assign c_target = slot_pc + {{43{ctl_instr[23]}}, ctl_instr[23:5], 2'b00};
  assign seq_pc   = pc + {59'b0, avail, 2'b00};

  assign ras_push_pc = slot_pc + 64'd4; // bl return address

  always_comb begin
    br_valid   = found;
    br_kind    = ctl_kind;
    br_slot    = ctl_slot;
    slot_count = found ? slot_cnt_t'(ctl_slot) + slot_cnt_t'(1) : avail;
    br_taken   = 1'b0;
    br_target  = '0;
    ras_push   = 1'b0;
    ras_pop    = 1'b0;
    case (ctl_kind)
      BR_B: begin
        br_taken  = 1'b1;
        br_target = b_target;
      end
      BR_BL: begin
        br_taken  = 1'b1;
        br_target = b_target;
        ras_push  = 1'b1;
      end
      BR_RET: begin
        br_taken  = 1'b1;
        br_target = ras_top;  // stale if the stack is empty
        ras_pop   = 1'b1;
      end
      BR_COND: begin
        br_taken  = cond_taken;
        br_target = c_target; // reported even when not taken
      end
      default: ;
    endcase
    if (br_taken) begin
      next_pc = br_target;
    end else if (found) begin
      next_pc = slot_pc + 64'd4;  // fall through past the b.cond
    end else begin
      next_pc = seq_pc;
    end
  end

endmodule

`default_nettype wire

//--- design/branch_pred.sv
`timescale 1ns/100ps
`default_nettype none

`include "bp_macros.svh"

module branch_pred import bp_pkg::*; (
  input  wire logic        clk_in,
  input  wire logic        rst_N_in,
  // resolve and redirect from execute
  input  wire logic        x_bcond_resolved,
  input  wire logic        x_taken,
  input  wire pc_t         x_pc,
  input  wire logic        x_pc_incorrect,
  input  wire logic [18:0] x_correction_offset, // signed byte offset from x_pc
  input  wire logic        fetch_credit,
  input  wire logic        l1i_valid,
  input  wire line_t       l1i_line,
  // bundle to fetch
  output logic             pc_valid,
  output pc_t              pred_pc,
  output line_t            fetch_line,
  output slot_cnt_t        slot_count,
  output logic             br_valid,
  output br_kind_t         br_kind,
  output slot_t            br_slot,
  output logic             br_taken,
  output pc_t              br_target,
  // l1i request
  output logic             l1i_req,
  output pc_t              l1i_addr
);

  localparam int OFF_BITS    = $clog2(`LINE_BYTES);
  localparam int CREDIT_BITS = $clog2(`FETCH_CREDITS + 1);

  pc_t                    pc_q;
  bp_state_t              state;
  logic [CREDIT_BITS-1:0] credits;

  logic      l0_hit;
  line_t     l0_line;
  logic      has_credit;
  logic      emit;        // bundle registered this edge
  logic      miss_req;    // l1i request registered this edge
  pc_t       redirect_pc;

  pc_t       pd_cond_pc;
  logic      cond_taken;
  slot_cnt_t pd_slot_count;
  logic      pd_br_valid;
  logic      pd_br_taken;
  br_kind_t  pd_br_kind;
  slot_t     pd_br_slot;
  pc_t       pd_br_target;
  pc_t       pd_next_pc;
  logic      pd_ras_push;
  logic      pd_ras_pop;
  pc_t       pd_ras_push_pc;
  pc_t       ras_top;

  l0_icache u_l0 (
    .clk_in    (clk_in),
    .rst_N_in  (rst_N_in),
    .lookup_pc (pc_q),
    .hit       (l0_hit),
    .line      (l0_line),
    .fill      (l1i_valid),   // every returning line gets written
    .fill_pc   (l1i_addr),    // awaited line address
    .fill_line (l1i_line)
  );

  gshare_pht u_pht (
    .clk_in        (clk_in),
    .rst_N_in      (rst_N_in),
    .resolve       (x_bcond_resolved),
    .taken         (x_taken),
    .resolve_pc    (x_pc),
    .lookup_pc     (pd_cond_pc),
    .predict_taken (cond_taken),
    .history       ()         // observation only
  );

  // ras moves only when a bundle actually leaves
  ret_addr_stack u_ras (
    .clk_in   (clk_in),
    .rst_N_in (rst_N_in),
    .push     (emit && pd_ras_push),
    .pop      (emit && pd_ras_pop),
    .push_pc  (pd_ras_push_pc),
    .top_pc   (ras_top)
  );

  predecode u_pd (
    .pc          (pc_q),
    .line        (l0_line),
    .ras_top     (ras_top),
    .cond_taken  (cond_taken),
    .cond_pc     (pd_cond_pc),
    .slot_count  (pd_slot_count),
    .br_valid    (pd_br_valid),
    .br_taken    (pd_br_taken),
    .br_kind     (pd_br_kind),
    .br_slot     (pd_br_slot),
    .br_target   (pd_br_target),
    .next_pc     (pd_next_pc),
    .ras_push    (pd_ras_push),
    .ras_pop     (pd_ras_pop),
    .ras_push_pc (pd_ras_push_pc)
  );

  assign has_credit  = (credits != '0);
  assign redirect_pc = x_pc + {{45{x_correction_offset[18]}}, x_correction_offset};

  // redirect wins over both bundle and miss
  assign emit     = (state == ST_LOOKUP) && l0_hit && has_credit && !x_pc_incorrect;
  assign miss_req = (state == ST_LOOKUP) && !l0_hit && has_credit && !x_pc_incorrect;

  always_ff @(posedge clk_in) begin
    if (rst_N_in) begin
      pc_q     <= `RESET_PC;
      state    <= ST_LOOKUP;
      credits  <= CREDIT_BITS'(`FETCH_CREDITS);
      pc_valid <= 1'b0;
      br_valid <= 1'b0;
      l1i_req  <= 1'b0;
      pred_pc  <= '0;
    end else begin
      if (x_pc_incorrect) begin
        pc_q <= redirect_pc;   // state untouched so a pending fill still lands
      end else if (emit) begin
        pc_q <= pd_next_pc;
      end

      case (state)
        ST_LOOKUP:  if (miss_req) state <= ST_WAIT_L1;
        ST_WAIT_L1: if (l1i_valid) state <= ST_LOOKUP;
        default:    state <= ST_LOOKUP;
      endcase

      // one credit per bundle out, one per pulse back
      case ({emit, fetch_credit})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: ;
      endcase

      pc_valid <= emit;
      br_valid <= emit && pd_br_valid;
      l1i_req  <= miss_req;    // single cycle pulse
      if (emit) begin
        pred_pc <= pc_q;
      end
    end
  end

  // bundle payload, qualified by pc_valid
  always_ff @(posedge clk_in) begin
    if (emit) begin
      fetch_line <= l0_line;
      slot_count <= pd_slot_count;
      br_kind    <= pd_br_kind;
      br_slot    <= pd_br_slot;
      br_taken   <= pd_br_taken;
      br_target  <= pd_br_target;
    end
    if (miss_req) begin
      l1i_addr <= {pc_q[63:OFF_BITS], {OFF_BITS{1'b0}}}; // line aligned, held until fill
    end
  end

endmodule

`default_nettype wire

//--- verif/tb_tests.svh
function automatic instr_t enc_jump(input logic link, input pc_t from, input pc_t to);
  pc_t d;
  d = (to - from) >> 2;
  return {link, 5'b00101, d[25:0]};   // b or bl
endfunction

function automatic instr_t enc_bcond(input pc_t from, input pc_t to);
  pc_t d;
  d = (to - from) >> 2;
  return {8'h54, d[18:0], 5'b00000};  // b.eq
endfunction

task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
  if (got !== exp) begin
    $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    errors++;
  end
endtask

task automatic start_test();
  while (mem_busy) @(negedge clk_in);   // no line in flight across reset
  hold_credits = 1'b0;
  rst_N_in = 1'b1;
  repeat (4) @(negedge clk_in);
  rst_N_in = 1'b0;
  model_pht = '{default: '0};
  model_ghr = '0;
endtask

task automatic finish_test(input string name, input int errs_before);
  tests_run++;
  $display("%s: %0d errors", name, errors - errs_before);
endtask

// waits for the next bundle and checks it
// BR_NONE means no branch
task automatic next_bundle(input pc_t pc, input int cnt, input br_kind_t kind,
                           input int slot, input logic tk, input pc_t tgt);
  int n;
  line_t exp_line;
  n = 0;
  @(negedge clk_in);
  while (!pc_valid && n < 100) begin
    @(negedge clk_in);
    n++;
  end
  if (!pc_valid) begin
    $display("no bundle arrived within 100 cycles, expected one at pc %h", pc);
    errors++;
  end else begin
    exp_line = line_at({pc[63:6], 6'b000000});   // whole line holding the bundle
    check_val("pred_pc", pred_pc, pc);
    check_val("slot_count", 64'(slot_count), 64'(cnt));
    check_val("br_valid", 64'(br_valid), 64'(kind != BR_NONE));
    if (fetch_line !== exp_line) begin
      $display("Mismatch at %0t: fetch_line got %h expected %h",
               $time, fetch_line, exp_line);
      errors++;
    end
    if (kind != BR_NONE) begin
      check_val("br_kind", 64'(br_kind), 64'(kind));
      check_val("br_slot", 64'(br_slot), 64'(slot));
      check_val("br_taken", 64'(br_taken), 64'(tk));
      check_val("br_target", br_target, tgt);
    end
  end
endtask

task automatic expect_req(input pc_t addr);
  int n;
  n = 0;
  @(negedge clk_in);
  while (!l1i_req && n < 100) begin
    @(negedge clk_in);
    n++;
  end
  if (!l1i_req) begin
    $display("no l1i request within 100 cycles, expected one at %h", addr);
    errors++;
  end else begin
    check_val("l1i_addr", l1i_addr, addr);
  end
endtask

task automatic expect_quiet(input int cycles);
  repeat (cycles) begin
    @(negedge clk_in);
    if (pc_valid) begin
      $display("a bundle at pc %h came out while no credit was left", pred_pc);
      errors++;
    end
  end
endtask

task automatic redirect(input pc_t xpc, input logic [18:0] off);
  x_pc = xpc;
  x_correction_offset = off;
  x_pc_incorrect = 1'b1;
  @(negedge clk_in);
  x_pc_incorrect = 1'b0;
endtask

// drives one resolve and updates the reference counters and history
task automatic resolve(input pc_t pc, input logic tk);
  logic [7:0] idx;
  idx = {model_ghr, pc[5:2]};
  if (tk && model_pht[idx] != 2'd3) model_pht[idx]++;
  if (!tk && model_pht[idx] != 2'd0) model_pht[idx]--;
  model_ghr = {model_ghr[2:0], tk};
  x_pc = pc;
  x_taken = tk;
  x_bcond_resolved = 1'b1;
  @(negedge clk_in);
  x_bcond_resolved = 1'b0;
endtask

task automatic sequential_fetch();
  int e;
  e = errors;
  words.delete();
  start_test();
  expect_req(64'h0);
  for (int i = 0; i < 4; i++) next_bundle(64'(16 * i), 4, BR_NONE, 0, 0, 0);
  expect_req(64'h40);
  redirect(64'd56, 19'd0);          // pending line 64 still lands
  next_bundle(64'd56, 2, BR_NONE, 0, 0, 0);
  next_bundle(64'd64, 4, BR_NONE, 0, 0, 0);
  finish_test("sequential fetch", e);
endtask

task automatic direct_branch();
  int e;
  e = errors;
  words.delete();
  words[64'h8] = enc_jump(1'b0, 64'h8, 64'h200);
  words[64'h204] = enc_jump(1'b0, 64'h204, 64'h40);   // backwards
  start_test();
  next_bundle(64'h0, 3, BR_B, 2, 1, 64'h200);
  next_bundle(64'h200, 2, BR_B, 1, 1, 64'h40);
  next_bundle(64'h40, 4, BR_NONE, 0, 0, 0);
  finish_test("direct branch", e);
endtask

task automatic call_return();
  int e;
  e = errors;
  words.delete();
  words[64'h0] = enc_jump(1'b1, 64'h0, 64'h440);
  words[64'h444] = enc_jump(1'b1, 64'h444, 64'h880);
  words[64'h888] = 32'hd65f03c0;
  words[64'h448] = 32'hd65f03c0;
  start_test();
  next_bundle(64'h0, 1, BR_BL, 0, 1, 64'h440);
  next_bundle(64'h440, 2, BR_BL, 1, 1, 64'h880);
  next_bundle(64'h880, 3, BR_RET, 2, 1, 64'h448);   // inner call returns first
  next_bundle(64'h448, 1, BR_RET, 0, 1, 64'h4);
  next_bundle(64'h4, 4, BR_NONE, 0, 0, 0);
  finish_test("call and return", e);
endtask

task automatic cond_prediction();
  int e;
  logic tk;
  e = errors;
  words.delete();
  words[64'h8] = enc_bcond(64'h8, 64'h300);
  start_test();
  next_bundle(64'h0, 3, BR_COND, 2, 0, 64'h300);
  next_bundle(64'hc, 4, BR_NONE, 0, 0, 0);
  for (int r = 0; r < 2; r++) begin
    resolve(64'h8, 1'b1);
    repeat (4) resolve(64'h3c, 1'b0);   // walk the history back to zero
  end
  tk = model_pht[{model_ghr, 4'h2}] >= 2'd2;
  redirect(64'h0, 19'd0);
  next_bundle(64'h0, 3, BR_COND, 2, tk, 64'h300);
  next_bundle(64'h300, 4, BR_NONE, 0, 0, 0);
  finish_test("conditional prediction", e);
endtask

task automatic redirect_check();
  int e;
  e = errors;
  words.delete();
  start_test();
  next_bundle(64'h0, 4, BR_NONE, 0, 0, 0);
  redirect(64'h100, -19'sd64);      // lands on 0xc0
  next_bundle(64'hc0, 4, BR_NONE, 0, 0, 0);
  redirect(64'h1f0, 19'd0);
  expect_req(64'h1c0);
  redirect(64'h1d0, -19'sd8);       // while the 0x1c0 line is in flight
  next_bundle(64'h1c8, 4, BR_NONE, 0, 0, 0);
  finish_test("redirect", e);
endtask

task automatic credit_backpressure();
  int e;
  e = errors;
  words.delete();
  start_test();
  hold_credits = 1'b1;
  for (int i = 0; i < `FETCH_CREDITS; i++) next_bundle(64'(16 * i), 4, BR_NONE, 0, 0, 0);
  expect_quiet(12);
  credit_pulses = 1;
  next_bundle(64'h40, 4, BR_NONE, 0, 0, 0);
  expect_quiet(12);
  finish_test("credit back-pressure", e);
endtask

//--- verif/tb_branch_pred.sv
`timescale 1ns/100ps
`default_nettype none

`include "bp_macros.svh"

module tb_branch_pred import bp_pkg::*; ();

  localparam int CLK_NS = 20;
  localparam int TEST_BUDGET = 300;                  // cycles per test
  localparam int BUDGET_NS = 6 * TEST_BUDGET * 2 * CLK_NS;

  logic clk_in, rst_N_in, x_bcond_resolved, x_taken, x_pc_incorrect;
  logic fetch_credit, l1i_valid;
  pc_t x_pc;
  logic [18:0] x_correction_offset;
  line_t l1i_line;
  logic pc_valid, br_valid, br_taken, l1i_req;
  pc_t pred_pc, br_target, l1i_addr;
  line_t fetch_line;
  slot_cnt_t slot_count;
  br_kind_t br_kind;
  slot_t br_slot;

  int seed = 72;
  int errors = 0;
  int tests_run = 0;
  logic hold_credits = 1'b0;   // fetch keeps its credits
  int credit_pulses = 0;       // extra single credits to hand back
  logic mem_busy = 1'b0;
  instr_t words [pc_t];        // program image, unset words are filler
  ctr_t model_pht [256];
  ghr_t model_ghr;

  branch_pred DUT (.*);

  initial begin
    clk_in = 1'b0;
    forever #(CLK_NS / 2) clk_in = ~clk_in;
  end

  // filler is an add-like word, never a control instruction
  function automatic instr_t fill_word(input pc_t a);
    return {8'h8b, a[23:0] ^ a[47:24] ^ {8'h00, a[63:48]}};
  endfunction

  function automatic line_t line_at(input pc_t base);
    line_t ln;
    pc_t a;
    for (int i = 0; i < 16; i++) begin
      a = base + 64'(4 * i);
      ln[32*i +: 32] = words.exists(a) ? words[a] : fill_word(a);
    end
    return ln;
  endfunction

  // l1i model, one request at a time, 1 to 4 cycles latency
  initial begin
    int lat;
    forever begin
      @(negedge clk_in);
      if (l1i_req) begin
        mem_busy = 1'b1;
        lat = ($random(seed) & 3) + 1;
        repeat (lat) @(negedge clk_in);
        l1i_line = line_at(l1i_addr);
        l1i_valid = 1'b1;
        @(negedge clk_in);
        l1i_valid = 1'b0;
        mem_busy = 1'b0;
      end
    end
  end

  // credit return from fetch, one per bundle seen
  initial begin
    forever begin
      @(negedge clk_in);
      if (credit_pulses > 0) begin
        fetch_credit = 1'b1;
        credit_pulses--;
      end else begin
        fetch_credit = pc_valid && !hold_credits;
      end
    end
  end

  `include "tb_tests.svh"

  initial begin
    rst_N_in = 1'b1;
    x_bcond_resolved = 1'b0;
    x_taken = 1'b0;
    x_pc = '0;
    x_pc_incorrect = 1'b0;
    x_correction_offset = '0;
    fetch_credit = 1'b0;
    l1i_valid = 1'b0;
    l1i_line = '0;
    sequential_fetch();
    direct_branch();
    call_return();
    cond_prediction();
    redirect_check();
    credit_backpressure();
    $display("tests run %0d, errors %0d", tests_run, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  // watchdog, twice the summed test budgets
  initial begin
    #(BUDGET_NS);
    $display("timeout: the tests did not finish in %0d ns", BUDGET_NS);
    $display("Result: FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
+incdir+design
+incdir+verif
design/bp_pkg.sv
design/ret_addr_stack.sv
design/l0_icache.sv
design/gshare_pht.sv
design/predecode.sv
design/branch_pred.sv
verif/tb_branch_pred.sv
